//--- bpu_cfg_pkg.sv
// ----------------------------------------
// sizes, index slicing and reset PC of the
// branch predictor, shared by every module
// ----------------------------------------
package bpu_cfg_pkg;

    localparam int PC_W = 32;
    typedef logic [PC_W-1:0] pc_t;

    // btb and bht share the same index bits, pc[7:2]
    localparam int BTB_IDX_W = 6;
    localparam int BTB_DEPTH = 1 << BTB_IDX_W;
    typedef logic [BTB_IDX_W-1:0] btb_idx_t;

    localparam int TAG_W = 8;              // pc[15:8]
    typedef logic [TAG_W-1:0] tag_t;

    localparam int HIST_W = 4;
    typedef logic [HIST_W-1:0] hist_t;

    localparam int PHT_PC_W = 4;           // pc[5:2]
    localparam int PHT_IDX_W = HIST_W + PHT_PC_W;
    localparam int PHT_DEPTH = 1 << PHT_IDX_W;
    typedef logic [PHT_IDX_W-1:0] pht_idx_t;

    typedef logic [1:0] scnt_t;
    localparam scnt_t SCNT_INIT = 2'b01;   // weakly not taken

    localparam int RAS_DEPTH = 8;
    typedef logic [$clog2(RAS_DEPTH)-1:0] ras_ptr_t;

    localparam int SWEEP_W = 8;            // covers the pht
    typedef logic [SWEEP_W-1:0] sweep_idx_t;

    localparam pc_t INIT_PC = 32'h1c00_0000;

    function automatic btb_idx_t get_btb_idx(input pc_t pc);
        return pc[BTB_IDX_W+1:2];
    endfunction

    function automatic tag_t get_tag(input pc_t pc);
        return pc[TAG_W+BTB_IDX_W+1:BTB_IDX_W+2];
    endfunction

    // history in the upper bits, low pc bits below
    function automatic pht_idx_t get_pht_idx(input hist_t hist, input pc_t pc);
        return {hist, pc[PHT_PC_W+1:2]};
    endfunction

endpackage

//--- bpu_msg_pkg.sv
// ----------------------------------------
// kinds, states and the packed records
// passed between predictor blocks
// ----------------------------------------
package bpu_msg_pkg;

    import bpu_cfg_pkg::*;

    typedef enum logic [1:0] {
        BR_COND,
        BR_JUMP,
        BR_CALL,
        BR_RET
    } br_kind_e;

    typedef enum logic [1:0] {
        SW_IDLE,
        SW_CLEAR,
        SW_RUN
    } sweep_state_e;

    // backend feedback, one per cycle
    typedef struct packed {
        logic     update;
        pc_t      pc;
        pc_t      target;
        br_kind_e kind;
        logic     taken;
        hist_t    history;   // as reported at predict time
        scnt_t    scnt;
    } correct_info_t;

    typedef struct packed {
        tag_t     tag;
        pc_t      target;
        br_kind_e kind;
    } btb_entry_t;

    // payload handed to fetch
    typedef struct packed {
        pc_t      pc;
        pc_t      next_pc;
        logic     hit;
        br_kind_e kind;
        logic     taken;
        hist_t    history;
        scnt_t    scnt;
    } predict_info_t;

    typedef struct packed {
        hist_t history;
        scnt_t scnt;
        logic  taken;     // counter msb only
    } dir_pred_t;

endpackage

//--- bpu_sweep_fsm.sv
// ----------------------------------------
// post-reset table clear sequencer, then
// holds prediction enabled
// ----------------------------------------
module bpu_sweep_fsm (
    input  logic clk,
    input  logic rst,
    input  logic last_i,
    output logic clear_en_o,
    output logic run_o
);

    import bpu_msg_pkg::*;

    sweep_state_e state_q;
    sweep_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SW_IDLE: begin
                state_d = SW_CLEAR;    // first cycle out of reset
            end
            SW_CLEAR: begin
                if (last_i) begin
                    state_d = SW_RUN;
                end
            end
            SW_RUN: begin
                state_d = SW_RUN;      // stays here until next reset
            end
            default: begin
                state_d = SW_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= SW_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign clear_en_o = (state_q == SW_CLEAR);
    assign run_o      = (state_q == SW_RUN);

endmodule

//--- bpu_sweep_counter.sv
// ----------------------------------------
// walks every table index during clearing
// ----------------------------------------
module bpu_sweep_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    en_i,
    output bpu_cfg_pkg::sweep_idx_t idx_o,
    output logic                    last_o
);

    import bpu_cfg_pkg::*;

    sweep_idx_t cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (en_i) begin
            cnt_q <= cnt_q + sweep_idx_t'(1);   // wraps back to 0 after the sweep
        end
    end

    assign idx_o  = cnt_q;
    assign last_o = (cnt_q == '1);

endmodule

//--- bpu_btb.sv
// ----------------------------------------
// tagged target buffer, async read at the
// fetch pc, written by sweep or backend
// ----------------------------------------
module bpu_btb (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear_en_i,
    input  bpu_cfg_pkg::sweep_idx_t     clear_idx_i,
    input  bpu_cfg_pkg::pc_t            pc_i,
    output logic                        hit_o,
    output bpu_msg_pkg::btb_entry_t     entry_o,
    input  bpu_msg_pkg::correct_info_t  correct_i
);

    import bpu_cfg_pkg::*;
    import bpu_msg_pkg::*;

    btb_entry_t           entries [BTB_DEPTH];
    logic [BTB_DEPTH-1:0] valid_q;

    btb_idx_t   rd_idx;
    btb_idx_t   wr_idx;
    btb_entry_t wr_entry;
    logic       wr_valid;
    logic       we;

    assign rd_idx = get_btb_idx(pc_i);

    // sweep owns the write port while clearing
    always_comb begin
        if (clear_en_i) begin
            wr_idx   = clear_idx_i[BTB_IDX_W-1:0];
            wr_entry = '0;
            wr_valid = 1'b0;
        end else begin
            wr_idx          = get_btb_idx(correct_i.pc);
            wr_entry.tag    = get_tag(correct_i.pc);
            wr_entry.target = correct_i.target;
            wr_entry.kind   = correct_i.kind;
            wr_valid        = 1'b1;
        end
    end

    assign we = clear_en_i || correct_i.update;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (we) begin
            valid_q[wr_idx] <= wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            entries[wr_idx] <= wr_entry;
        end
    end

    assign entry_o = entries[rd_idx];
    assign hit_o   = valid_q[rd_idx] && (entry_o.tag == get_tag(pc_i));   // tag from pc[15:8]

endmodule

//--- bpu_dir_predictor.sv
// ----------------------------------------
// local history table feeding a table of
// 2-bit counters, trained by the backend
// ----------------------------------------
module bpu_dir_predictor (
    input  logic                        clk,
    input  logic                        clear_en_i,
    input  bpu_cfg_pkg::sweep_idx_t     clear_idx_i,
    input  bpu_cfg_pkg::pc_t            pc_i,
    output bpu_msg_pkg::dir_pred_t      pred_o,
    input  bpu_msg_pkg::correct_info_t  correct_i
);

    import bpu_cfg_pkg::*;
    import bpu_msg_pkg::*;

    hist_t bht [BTB_DEPTH];    // same pc bits as the btb
    scnt_t pht [PHT_DEPTH];

    hist_t    rd_hist;
    pht_idx_t rd_pht_idx;
    btb_idx_t wr_bht_idx;
    pht_idx_t wr_pht_idx;
    hist_t    wr_hist;
    scnt_t    wr_scnt;

    // saturating step from the value the backend echoed back
    function automatic scnt_t next_scnt(input scnt_t cur, input logic taken);
        if (taken) begin
            return (cur == 2'b11) ? cur : cur + scnt_t'(1);
        end
        return (cur == 2'b00) ? cur : cur - scnt_t'(1);
    endfunction

    // read path
    assign rd_hist    = bht[get_btb_idx(pc_i)];
    assign rd_pht_idx = get_pht_idx(rd_hist, pc_i);

    assign pred_o.history = rd_hist;
    assign pred_o.scnt    = pht[rd_pht_idx];
    assign pred_o.taken   = pred_o.scnt[1];

    // training path, indexed by the reported history
    assign wr_bht_idx = get_btb_idx(correct_i.pc);
    assign wr_pht_idx = get_pht_idx(correct_i.history, correct_i.pc);
    assign wr_hist    = {correct_i.history[HIST_W-2:0], correct_i.taken};
    assign wr_scnt    = next_scnt(correct_i.scnt, correct_i.taken);

    always_ff @(posedge clk) begin
        if (clear_en_i) begin
            // bht wraps over the sweep several times
            bht[clear_idx_i[BTB_IDX_W-1:0]] <= '0;
            pht[clear_idx_i[PHT_IDX_W-1:0]] <= SCNT_INIT;
        end else if (correct_i.update) begin
            bht[wr_bht_idx] <= wr_hist;
            pht[wr_pht_idx] <= wr_scnt;
        end
    end

endmodule

//--- bpu_ras.sv
// ----------------------------------------
// return stack, grows upward and wraps,
// changed only by backend corrections
// ----------------------------------------
module bpu_ras (
    input  logic                        clk,
    input  logic                        rst,
    input  bpu_msg_pkg::correct_info_t  correct_i,
    output bpu_cfg_pkg::pc_t            top_o
);

    import bpu_cfg_pkg::*;
    import bpu_msg_pkg::*;

    pc_t      stack [RAS_DEPTH];
    ras_ptr_t top_ptr_q;    // current top entry
    ras_ptr_t wr_ptr;       // slot above the top
    logic     push;
    logic     pop;

    assign push   = correct_i.update && (correct_i.kind == BR_CALL);
    assign pop    = correct_i.update && (correct_i.kind == BR_RET);
    assign wr_ptr = top_ptr_q + ras_ptr_t'(1);

    always_ff @(posedge clk) begin
        if (push) begin
            stack[wr_ptr] <= correct_i.pc + pc_t'(4);   // return address
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr_q <= '1;
        end else if (push) begin
            top_ptr_q <= wr_ptr;
        end else if (pop) begin
            top_ptr_q <= top_ptr_q - ras_ptr_t'(1);
        end
    end

    assign top_o = stack[top_ptr_q];

endmodule

//--- bpu_fetch_pc.sv
// ----------------------------------------
// fetch pc register, next-pc select and
// the valid/ready stream toward fetch
// ----------------------------------------
module bpu_fetch_pc (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        run_i,
    input  logic                        flush_i,
    input  bpu_cfg_pkg::pc_t            redir_pc_i,
    input  logic                        hit_i,
    input  bpu_msg_pkg::btb_entry_t     entry_i,
    input  bpu_msg_pkg::dir_pred_t      dir_i,
    input  bpu_cfg_pkg::pc_t            ras_top_i,
    output bpu_cfg_pkg::pc_t            pc_o,
    input  logic                        fetch_ready_i,
    output logic                        fetch_valid_o,
    output bpu_msg_pkg::predict_info_t  fetch_data_o
);

    import bpu_cfg_pkg::*;
    import bpu_msg_pkg::*;

    pc_t           pc_q;
    pc_t           target;
    logic          taken;
    logic          fire;
    logic          stall_q;
    predict_info_t live_data;
    predict_info_t held_q;

    // unconditional kinds always jump on a hit
    assign taken  = hit_i && ((entry_i.kind != BR_COND) || dir_i.taken);
    assign target = (entry_i.kind == BR_RET) ? ras_top_i : entry_i.target;

    always_comb begin
        live_data.pc      = pc_q;
        live_data.next_pc = taken ? target : pc_q + pc_t'(4);
        live_data.hit     = hit_i;
        live_data.kind    = entry_i.kind;
        live_data.taken   = taken;
        live_data.history = dir_i.history;
        live_data.scnt    = dir_i.scnt;
    end

    assign fetch_valid_o = run_i;
    assign fire          = run_i && fetch_ready_i;

    // priority: flush, hold, offered next pc
    always_ff @(posedge clk) begin
        if (rst || !run_i) begin
            pc_q <= INIT_PC;
        end else if (flush_i) begin
            pc_q <= redir_pc_i;
        end else if (fire) begin
            pc_q <= fetch_data_o.next_pc;
        end
    end

    // freeze the offered payload so a correction under back-pressure can't change it
    always_ff @(posedge clk) begin
        if (rst) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= run_i && !fetch_ready_i && !flush_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_q) begin
            held_q <= live_data;
        end
    end

    assign fetch_data_o = stall_q ? held_q : live_data;
    assign pc_o         = pc_q;

endmodule

//--- bpu_top.sv
// ----------------------------------------
// branch predictor top, one prediction per
// cycle to fetch, trained by the backend
// ----------------------------------------
module bpu_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush_i,
    input  bpu_cfg_pkg::pc_t            redir_pc_i,
    input  bpu_msg_pkg::correct_info_t  correct_i,
    input  logic                        fetch_ready_i,
    output logic                        fetch_valid_o,
    output bpu_msg_pkg::predict_info_t  fetch_data_o
);

    import bpu_cfg_pkg::*;
    import bpu_msg_pkg::*;

    logic       clear_en;
    logic       run;
    logic       last;
    sweep_idx_t clear_idx;
    pc_t        pc;
    logic       btb_hit;
    btb_entry_t btb_entry;
    dir_pred_t  dir_pred;
    pc_t        ras_top;

    // clearing control
    bpu_sweep_fsm sweep_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .last_i     (last),
        .clear_en_o (clear_en),
        .run_o      (run)
    );

    bpu_sweep_counter sweep_counter_i (
        .clk    (clk),
        .rst    (rst),
        .en_i   (clear_en),
        .idx_o  (clear_idx),
        .last_o (last)
    );

    // tables
    bpu_btb btb_i (
        .clk         (clk),
        .rst         (rst),
        .clear_en_i  (clear_en),
        .clear_idx_i (clear_idx),
        .pc_i        (pc),
        .hit_o       (btb_hit),
        .entry_o     (btb_entry),
        .correct_i   (correct_i)
    );

    bpu_dir_predictor dir_predictor_i (
        .clk         (clk),
        .clear_en_i  (clear_en),
        .clear_idx_i (clear_idx),
        .pc_i        (pc),
        .pred_o      (dir_pred),
        .correct_i   (correct_i)
    );

    bpu_ras ras_i (
        .clk       (clk),
        .rst       (rst),
        .correct_i (correct_i),
        .top_o     (ras_top)
    );

    bpu_fetch_pc fetch_pc_i (
        .clk           (clk),
        .rst           (rst),
        .run_i         (run),
        .flush_i       (flush_i),
        .redir_pc_i    (redir_pc_i),
        .hit_i         (btb_hit),
        .entry_i       (btb_entry),
        .dir_i         (dir_pred),
        .ras_top_i     (ras_top),
        .pc_o          (pc),
        .fetch_ready_i (fetch_ready_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o)
    );

endmodule

//--- tb_bpu.sv
// ----------------------------------------
// testbench for bpu_top, replays the golden
// records and checks every fetch transfer
// ----------------------------------------
module tb_bpu;

    import bpu_cfg_pkg::*;
    import bpu_msg_pkg::*;

    localparam int BOOT_LIMIT = 400;   // cycles allowed for the clearing sweep
    localparam int XFER_LIMIT = 64;
    localparam int CLEAR_CYCLES = 256;

    logic          clk;
    logic          rst;
    logic          flush_i;
    pc_t           redir_pc_i;
    correct_info_t correct_i;
    logic          fetch_ready_i;
    logic          fetch_valid_o;
    predict_info_t fetch_data_o;

    integer seed = 32'h987a_2a7d;
    logic   gaps_on;                   // random ready gaps while waiting

    bpu_top bpu_top_i (
        .clk           (clk),
        .rst           (rst),
        .flush_i       (flush_i),
        .redir_pc_i    (redir_pc_i),
        .correct_i     (correct_i),
        .fetch_ready_i (fetch_ready_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_data_o  (fetch_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            fail_now($sformatf("FAIL %s pc expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_pred(input string name, input predict_info_t exp,
                              input predict_info_t act);
        if (act !== exp) begin
            fail_now($sformatf("FAIL %s expected %h actual %h", name, exp, act));
        end
    endtask

    // inputs change 5 units after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic wait_boot();
        int low_cycles;
        low_cycles = 0;
        step_cycle();                  // first edge that sees rst low
        #15;
        while (!fetch_valid_o) begin
            low_cycles++;
            if (low_cycles > BOOT_LIMIT) begin
                fail_now("fetch_valid_o never rose after reset");
            end
            @(posedge clk);
            #20;
        end
        if (low_cycles != CLEAR_CYCLES) begin
            fail_now($sformatf("fetch_valid_o rose after %0d clearing cycles, not 256",
                               low_cycles));
        end
        step_cycle();
    endtask

    // offer ready until one transfer happens, checking every valid sample
    task automatic take_transfer(input string name, input predict_info_t exp);
        int          waited;
        logic [31:0] rnd;
        logic        done;
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            rnd           = $random(seed);
            fetch_ready_i = gaps_on ? rnd[0] : 1'b1;
            #15;                       // sample mid-cycle
            if (fetch_valid_o) begin
                check_pc(name, exp.pc, fetch_data_o.pc);
                check_pred(name, exp, fetch_data_o);
                done = fetch_ready_i;
            end
            waited++;
            if (!done && waited > XFER_LIMIT) begin
                fail_now($sformatf("no transfer for %s within %0d cycles", name, XFER_LIMIT));
            end
            @(posedge clk);
            #5;
        end
        fetch_ready_i = 1'b0;
    endtask

    initial begin
        int              fd;
        int              n;
        logic [7:0]      cmd;
        logic [8*24-1:0] tname;
        logic [8*128-1:0] rest;
        logic [31:0]     f0, f1, f2, f3, f4, f5, f6;
        predict_info_t   exp;
        correct_info_t   corr;
        logic            at_end;

        rst           = 1'b1;
        flush_i       = 1'b0;
        redir_pc_i    = '0;
        correct_i     = '0;
        fetch_ready_i = 1'b0;
        gaps_on       = 1'b0;
        at_end        = 1'b0;

        fd = $fopen("bpu_golden.txt", "r");
        if (fd == 0) begin
            fail_now("cannot open bpu_golden.txt");
        end

        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
        wait_boot();

        while (!at_end) begin
            n = $fscanf(fd, " %c", cmd);
            if (n != 1) begin
                at_end = 1'b1;
            end else if (cmd == "#") begin
                n = $fgets(rest, fd);  // column notes
            end else if (cmd == "e") begin
                n = $fscanf(fd, "%s %h %h %h %h %h %h %h", tname, f0, f1, f2, f3, f4, f5, f6);
                if (n != 8) begin
                    fail_now("malformed expect record in golden file");
                end
                exp.pc      = f0;
                exp.next_pc = f1;
                exp.hit     = f2[0];
                exp.kind    = br_kind_e'(f3[1:0]);
                exp.taken   = f4[0];
                exp.history = f5[HIST_W-1:0];
                exp.scnt    = f6[1:0];
                take_transfer($sformatf("%0s", tname), exp);
            end else if (cmd == "c") begin
                n = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, f2, f3, f4, f5);
                if (n != 6) begin
                    fail_now("malformed correction record in golden file");
                end
                corr.update  = 1'b1;
                corr.pc      = f0;
                corr.target  = f1;
                corr.kind    = br_kind_e'(f2[1:0]);
                corr.taken   = f3[0];
                corr.history = f4[HIST_W-1:0];
                corr.scnt    = f5[1:0];
                correct_i    = corr;
                step_cycle();          // one cycle of update
                correct_i    = '0;
            end else if (cmd == "f") begin
                n = $fscanf(fd, "%h", f0);
                flush_i       = 1'b1;
                redir_pc_i    = f0;
                fetch_ready_i = 1'b0;
                step_cycle();
                flush_i       = 1'b0;
            end else if (cmd == "g") begin
                n = $fscanf(fd, "%h", f0);
                gaps_on = f0[0];
            end else if (cmd == "w") begin
                n = $fscanf(fd, "%h", f0);
                repeat (int'(f0)) step_cycle();   // idle with ready low
            end else begin
                fail_now($sformatf("unknown record type %c in golden file", cmd));
            end
        end

        $fclose(fd);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- bpu_golden.txt
# c pc target kind taken history scnt | f redir_pc | g gaps_on | w idle_cycles
# e name pc next_pc hit kind taken history scnt (hex; kind 0 cond 1 jump 2 call 3 ret)
e boot_0 1c000000 1c000004 0 0 0 0 1
e boot_1 1c000004 1c000008 0 0 0 0 1
e boot_2 1c000008 1c00000c 0 0 0 0 1
c 1c000120 1c000400 1 1 0 1
f 1c000120
e jump_hit 1c000120 1c000400 1 1 1 1 1
e jump_tgt 1c000400 1c000404 0 0 0 0 1
c 1c000248 1c000300 0 1 f 1
f 1c000248
e cond_weak 1c000248 1c000300 1 0 1 f 2
c 1c000248 1c000300 0 1 f 2
c 1c000248 1c000300 0 1 f 3
f 1c000248
e cond_sat 1c000248 1c000300 1 0 1 f 3
c 1c000248 1c000300 0 0 f 3
f 1c000248
e cond_hist 1c000248 1c00024c 1 0 0 e 1
c 1c000248 1c000300 0 1 7 1
f 1c000248
e cond_down 1c000248 1c000300 1 0 1 f 2
c 1c000530 1c000800 2 1 0 1
c 1c000840 00000000 3 1 0 1
c 1c000530 1c000800 2 1 0 1
c 1c000634 1c000800 2 1 0 1
f 1c000840
e ret_call 1c000840 1c000638 1 3 1 1 1
c 1c000840 00000000 3 1 1 1
f 1c000840
e ret_pop 1c000840 1c000534 1 3 1 3 1
g 1
f 1c000904
e gap_0 1c000904 1c000908 0 0 0 0 1
e gap_1 1c000908 1c00090c 0 0 0 0 1
e gap_2 1c00090c 1c000910 0 0 0 0 1
e gap_3 1c000910 1c000914 0 0 0 0 1
w 3
f 1c000a14
e flush_bp 1c000a14 1c000a18 0 0 0 0 1
e flush_seq 1c000a18 1c000a1c 0 0 0 0 1

//--- flist.f
bpu_cfg_pkg.sv
bpu_msg_pkg.sv
bpu_sweep_fsm.sv
bpu_sweep_counter.sv
bpu_btb.sv
bpu_dir_predictor.sv
bpu_ras.sv
bpu_fetch_pc.sv
bpu_top.sv
tb_bpu.sv

//--- run_sim.sh
#!/bin/sh
# build the branch predictor testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_bpu -o sim_bpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_bpu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
